//--- regex_coprocessor.f
hdl/regex_pkg.sv
hdl/coprocessor_fsm.sv
hdl/string_cursor.sv
hdl/char_buffer.sv
hdl/regex_engine.sv
hdl/memory_arbiter.sv
hdl/regex_coprocessor.sv
bench/regex_coprocessor_checker.sv
bench/regex_coprocessor_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := regex_coprocessor_tb
FILELIST  := regex_coprocessor.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/regex_coprocessor_tb.sv
//**********************************************************
// testbench with clock, reset, memory model, random jobs,
// reference model and result checks
//**********************************************************
module regex_coprocessor_tb
    import regex_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH  = 11;
    localparam int PC_WIDTH    = 8;
    localparam int PTR_WIDTH   = ADDR_WIDTH + 1;
    localparam int JOB_TIMEOUT = 2000;
    localparam int PROG_MAX    = 10;
    localparam int STR_MAX     = 12;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    logic                  ready;
    logic [PTR_WIDTH-1:0]  start_pointer;
    logic [PTR_WIDTH-1:0]  end_pointer;
    logic                  memory_valid;
    logic                  memory_ready;
    logic [ADDR_WIDTH-1:0] memory_addr;
    logic [WORD_WIDTH-1:0] memory_data;
    logic                  done;
    logic                  accept;
    logic                  error;

    // word memory shared by program and strings
    logic [WORD_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];
    opcode_e               prog_op [0:PROG_MAX-1];
    logic [CHAR_WIDTH-1:0] prog_arg [0:PROG_MAX-1];
    logic [CHAR_WIDTH-1:0] str [0:STR_MAX-1];
    integer                seed       = 94;
    integer                stall_seed = 94;
    logic                  stall_on;
    logic                  timed_out;
    // first and last word of the string of the running job
    int                    str_lo;
    int                    str_hi;
    int                    checks;
    int                    errors;

    regex_coprocessor #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .PC_WIDTH   (PC_WIDTH)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .ready         (ready),
        .start_pointer (start_pointer),
        .end_pointer   (end_pointer),
        .memory_valid  (memory_valid),
        .memory_ready  (memory_ready),
        .memory_addr   (memory_addr),
        .memory_data   (memory_data),
        .done          (done),
        .accept        (accept),
        .error         (error)
    );

    bind regex_coprocessor regex_coprocessor_checker #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .memory_valid (memory_valid),
        .memory_ready (memory_ready),
        .memory_addr  (memory_addr),
        .done         (done),
        .accept       (accept),
        .error        (error)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // memory model answers with the word the cycle after its transfer
    initial
    begin
        logic                  xfer;
        logic [ADDR_WIDTH-1:0] xfer_addr;
        forever
        begin
            // port is stable at the falling edge since inputs move after the rising one
            @(negedge clk);
            xfer      = memory_valid && memory_ready;
            xfer_addr = memory_addr;
            // only program words and the words of the current string are read
            if (xfer && !rst)
            begin
                checks++;
                if (xfer_addr >= PROG_MAX && (xfer_addr < str_lo || xfer_addr > str_hi))
                begin
                    $display("FAILED: memory_addr = %h, outside program and string words",
                             xfer_addr);
                    errors++;
                end
            end
            @(posedge clk);
            #1;
            if (xfer)
                memory_data = mem[xfer_addr];
            // about one stall cycle in four when back-pressure is on
            memory_ready = !stall_on || (($unsigned($random(stall_seed)) & 32'd3) != 32'd0);
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // reference walk of the program over the string
    function automatic logic model_verdict(input int len);
        int pc;
        int pos;
        int steps;
        pc  = 0;
        pos = 0;
        for (steps = 0; steps < 4 * PROG_MAX; steps++)
        begin
            case (prog_op[pc])
                OP_ACCEPT:
                    return 1'b1;
                OP_JMP:
                    pc = int'(prog_arg[pc]);
                OP_MATCH_ANY:
                begin
                    if (pos >= len)
                        return 1'b0;
                    pos++;
                    pc++;
                end
                default:
                begin
                    // literal match needs a char left and an equal one
                    if (pos >= len || str[pos] != prog_arg[pc])
                        return 1'b0;
                    pos++;
                    pc++;
                end
            endcase
        end
        return 1'b0;
    endfunction

    task automatic expect_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected)
        begin
            $display("FAILED: %s = %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // program from word 0, string from word base, low byte first
    task automatic write_job(input int base, input int len, input int n);
        int i;
        for (i = 0; i < n; i++)
            mem[i] = {prog_op[i], 6'b000000, prog_arg[i]};
        for (i = 0; i < len; i++)
            mem[base + i / 2][(i % 2) * CHAR_WIDTH +: CHAR_WIDTH] = str[i];
    endtask

    task automatic gen_job(output int base, output int len);
        int i;
        int n;
        int r;
        int pos;
        len  = 1 + rand_below(STR_MAX);
        base = 64 + rand_below(1024);
        // four letter alphabet so random literals hit now and then
        for (i = 0; i < len; i++)
            str[i] = 8'(8'h61 + rand_below(4));
        n   = 2 + rand_below(PROG_MAX - 1);
        pos = 0;
        for (i = 0; i < n - 1; i++)
        begin
            r           = rand_below(8);
            prog_arg[i] = 8'(8'h61 + rand_below(4));
            if (r < 4)
            begin
                prog_op[i] = OP_MATCH_CHAR;
                // mostly follow the string so some jobs match
                if (pos < len && r != 0)
                    prog_arg[i] = str[pos];
                pos++;
            end
            else if (r < 6)
            begin
                prog_op[i] = OP_MATCH_ANY;
                pos++;
            end
            else if (r == 6)
            begin
                // forward target only
                prog_op[i]  = OP_JMP;
                prog_arg[i] = 8'(i + 1 + rand_below(n - 1 - i));
            end
            else
                prog_op[i] = OP_ACCEPT;
        end
        prog_op[n-1]  = OP_ACCEPT;
        prog_arg[n-1] = 8'h00;
        write_job(base, len, n);
    endtask

    task automatic run_job(input int base, input int len, input logic expected);
        int cycles;
        if (timed_out)
            return;
        cycles = 0;
        while (!ready && cycles < JOB_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ready)
        begin
            $display("ready stayed low so the job could not be issued");
            errors++;
            timed_out = 1'b1;
            return;
        end
        str_lo        = base;
        str_hi        = base + (len - 1) / CHARS_PER_WORD;
        start_pointer = PTR_WIDTH'(base * CHARS_PER_WORD);
        end_pointer   = PTR_WIDTH'(base * CHARS_PER_WORD + len - 1);
        valid         = 1'b1;
        @(posedge clk);
        #1;
        valid  = 1'b0;
        cycles = 0;
        while (!done && cycles < JOB_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done)
        begin
            $display("no done pulse within the job timeout");
            errors++;
            timed_out = 1'b1;
            return;
        end
        checks++;
        if (accept !== expected)
        begin
            $display("FAILED: accept = %h, expected %h, string length %0d", accept, expected, len);
            errors++;
        end
        expect_bit("error", error, 1'b0);
        // done lasts one cycle and ready returns with idle
        @(posedge clk);
        #1;
        expect_bit("done", done, 1'b0);
        expect_bit("ready", ready, 1'b1);
    endtask

    // odd start pointer lands in the sticky error state
    task automatic check_bad_start();
        int cycles;
        if (timed_out)
            return;
        start_pointer = PTR_WIDTH'(201);
        end_pointer   = PTR_WIDTH'(210);
        valid         = 1'b1;
        @(posedge clk);
        #1;
        valid = 1'b0;
        expect_bit("error", error, 1'b1);
        for (cycles = 0; cycles < 20; cycles++)
        begin
            @(posedge clk);
            #1;
            expect_bit("error", error, 1'b1);
            expect_bit("done", done, 1'b0);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16)
            @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic check_idle();
        expect_bit("done", done, 1'b0);
        expect_bit("accept", accept, 1'b0);
        expect_bit("error", error, 1'b0);
        expect_bit("memory_valid", memory_valid, 1'b0);
        expect_bit("ready", ready, 1'b1);
    endtask

    initial
    begin
        int base;
        int len;
        int job;
        int a;
        rst           = 1'b1;
        valid         = 1'b0;
        start_pointer = '0;
        end_pointer   = '0;
        memory_ready  = 1'b1;
        memory_data   = '0;
        stall_on      = 1'b0;
        timed_out     = 1'b0;
        str_lo        = 0;
        str_hi        = 0;
        checks        = 0;
        errors        = 0;
        for (a = 0; a < (1 << ADDR_WIDTH); a++)
            mem[a] = WORD_WIDTH'(a) ^ 16'hc35a;
        apply_reset();
        check_idle();
        // back-to-back random jobs on a free port
        for (job = 0; job < 40; job++)
        begin
            gen_job(base, len);
            run_job(base, len, model_verdict(len));
        end
        // same mix with random back-pressure
        stall_on = 1'b1;
        for (job = 0; job < 40; job++)
        begin
            gen_job(base, len);
            run_job(base, len, model_verdict(len));
        end
        // five chars wanted from a three char string
        for (a = 0; a < 5; a++)
            prog_op[a] = OP_MATCH_ANY;
        prog_op[5] = OP_ACCEPT;
        for (a = 0; a < 8; a++)
            str[a] = 8'(8'h61 + a);
        write_job(300, 3, 6);
        run_job(300, 3, 1'b0);
        // accept after one char of eight
        prog_op[0]  = OP_MATCH_CHAR;
        prog_arg[0] = 8'h61;
        prog_op[1]  = OP_ACCEPT;
        write_job(400, 8, 2);
        run_job(400, 8, 1'b1);
        check_bad_start();
        apply_reset();
        check_idle();
        gen_job(base, len);
        run_job(base, len, model_verdict(len));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- bench/regex_coprocessor_checker.sv
//**********************************************************
// bound assertions on memory request hold, done/error
// exclusion and accept qualified by done
//**********************************************************
module regex_coprocessor_checker
#(
    parameter int ADDR_WIDTH = 11
)
(
    input logic                  clk,
    input logic                  rst,
    input logic                  memory_valid,
    input logic                  memory_ready,
    input logic [ADDR_WIDTH-1:0] memory_addr,
    input logic                  done,
    input logic                  accept,
    input logic                  error
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled request keeps valid and address until it transfers
    request_held: assert property (@(posedge clk) disable iff (rst)
        memory_valid && !memory_ready |=> memory_valid && $stable(memory_addr))
    else
        $error("memory request dropped or moved while memory_ready was low");

    // a rejected job never completes
    done_error_excl: assert property (@(posedge clk) disable iff (rst)
        !(done && error))
    else
        $error("done and error were high in the same cycle");

    accept_with_done: assert property (@(posedge clk) disable iff (rst)
        accept |-> done)
    else
        $error("accept was high without done");

endmodule

//--- hdl/regex_coprocessor.sv
//**********************************************************
// regex coprocessor top level, joins job FSM, cursor, char
// buffer, engine and memory arbiter
//**********************************************************
module regex_coprocessor
    import regex_pkg::*;
#(
    parameter int ADDR_WIDTH = 11,
    parameter int PC_WIDTH   = 8
)
(
    input  logic                  clk,
    input  logic                  rst,
    // job port
    input  logic                  valid,
    output logic                  ready,
    input  logic [ADDR_WIDTH:0]   start_pointer,
    input  logic [ADDR_WIDTH:0]   end_pointer,
    // shared memory port
    output logic                  memory_valid,
    input  logic                  memory_ready,
    output logic [ADDR_WIDTH-1:0] memory_addr,
    input  logic [WORD_WIDTH-1:0] memory_data,
    // result
    output logic                  done,
    output logic                  accept,
    output logic                  error
);
    mem_req_t              char_req;
    mem_req_t              instr_req;
    engine_status_t        status;
    logic                  char_grant;
    logic                  instr_grant;
    logic                  char_word_valid;
    logic                  instr_valid;
    logic                  load_start;
    logic                  advance;
    logic                  word_load;
    logic                  char_ready;
    logic                  engine_start;
    logic [ADDR_WIDTH:0]   char_addr;
    logic [ADDR_WIDTH-1:0] word_addr;
    logic                  word_boundary;
    logic                  past_end;
    logic [CHAR_WIDTH-1:0] cur_char;

    coprocessor_fsm #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fsm (
        .clk             (clk),
        .rst             (rst),
        .valid           (valid),
        .ready           (ready),
        .start_pointer   (start_pointer),
        .end_pointer     (end_pointer),
        .word_addr       (word_addr),
        .word_boundary   (word_boundary),
        .past_end        (past_end),
        .char_grant      (char_grant),
        .char_word_valid (char_word_valid),
        .char_req        (char_req),
        .load_start      (load_start),
        .advance         (advance),
        .word_load       (word_load),
        .char_ready      (char_ready),
        .engine_start    (engine_start),
        .status          (status),
        .done            (done),
        .accept          (accept),
        .error           (error)
    );

    string_cursor #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_cursor (
        .clk           (clk),
        .rst           (rst),
        .load_start    (load_start),
        .start_pointer (start_pointer),
        .end_pointer   (end_pointer),
        .advance       (advance),
        .char_addr     (char_addr),
        .word_addr     (word_addr),
        .word_boundary (word_boundary),
        .past_end      (past_end)
    );

    // low pointer bits pick the character inside the buffered word
    char_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .word_load   (word_load),
        .memory_data (memory_data),
        .char_sel    (char_addr[CHAR_SEL_BITS-1:0]),
        .cur_char    (cur_char)
    );

    regex_engine #(
        .PC_WIDTH (PC_WIDTH)
    ) u_engine (
        .clk          (clk),
        .rst          (rst),
        .engine_start (engine_start),
        .char_ready   (char_ready),
        .cur_char     (cur_char),
        .past_end     (past_end),
        .instr_req    (instr_req),
        .instr_grant  (instr_grant),
        .instr_valid  (instr_valid),
        .memory_data  (memory_data),
        .status       (status)
    );

    memory_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .char_req        (char_req),
        .instr_req       (instr_req),
        .char_grant      (char_grant),
        .instr_grant     (instr_grant),
        .char_word_valid (char_word_valid),
        .instr_valid     (instr_valid),
        .memory_valid    (memory_valid),
        .memory_ready    (memory_ready),
        .memory_addr     (memory_addr)
    );

endmodule

//--- hdl/memory_arbiter.sv
//**********************************************************
// fixed priority memory arbiter, char side over instruction
// side, with response strobe routing
//**********************************************************
module memory_arbiter
    import regex_pkg::*;
#(
    parameter int ADDR_WIDTH = 11
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_req_t              char_req,
    input  mem_req_t              instr_req,
    output logic                  char_grant,
    output logic                  instr_grant,
    output logic                  char_word_valid,
    output logic                  instr_valid,
    output logic                  memory_valid,
    input  logic                  memory_ready,
    output logic [ADDR_WIDTH-1:0] memory_addr
);
    // a stalled request keeps the port, so valid and addr stay put
    logic hold_q;
    logic hold_char_q;
    logic pick_char;

    assign pick_char    = hold_q ? hold_char_q : char_req.valid;
    assign memory_valid = pick_char ? char_req.valid : instr_req.valid;
    assign memory_addr  = pick_char ? char_req.addr[ADDR_WIDTH-1:0]
                                    : instr_req.addr[ADDR_WIDTH-1:0];
    assign char_grant   = pick_char && char_req.valid && memory_ready;
    assign instr_grant  = !pick_char && instr_req.valid && memory_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hold_q          <= 1'b0;
            hold_char_q     <= 1'b0;
            char_word_valid <= 1'b0;
            instr_valid     <= 1'b0;
        end
        else
        begin
            hold_q          <= memory_valid && !memory_ready;
            hold_char_q     <= pick_char;
            // memory answers the cycle after the transfer
            char_word_valid <= char_grant;
            instr_valid     <= instr_grant;
        end
    end

endmodule

//--- hdl/regex_engine.sv
//**********************************************************
// single thread engine with instruction fetch, decode and
// match against the current character
//**********************************************************
module regex_engine
    import regex_pkg::*;
#(
    parameter int PC_WIDTH = 8
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  engine_start,
    input  logic                  char_ready,
    input  logic [CHAR_WIDTH-1:0] cur_char,
    input  logic                  past_end,
    output mem_req_t              instr_req,
    input  logic                  instr_grant,
    input  logic                  instr_valid,
    input  logic [WORD_WIDTH-1:0] memory_data,
    output engine_status_t        status
);
    engine_phase_e       phase;
    logic [PC_WIDTH-1:0] pc;
    instr_t              instr;
    // fetch transferred and waiting for its word
    logic                fetch_sent;
    logic                char_hit;

    // any-match only needs a char inside the string
    assign char_hit = !past_end &&
                      ((instr.opcode == OP_MATCH_ANY) || (cur_char == instr.operand));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase      <= PH_IDLE;
            pc         <= '0;
            fetch_sent <= 1'b0;
            status     <= '0;
        end
        else if (engine_start)
        begin
            // per job flush
            phase      <= PH_FETCH;
            pc         <= '0;
            fetch_sent <= 1'b0;
            status     <= '{running: 1'b1, accepted: 1'b0, consumed: 1'b0};
        end
        else
        begin
            status.consumed <= 1'b0;
            case (phase)
                PH_FETCH:
                begin
                    if (instr_valid)
                    begin
                        fetch_sent <= 1'b0;
                        phase      <= PH_DECODE;
                    end
                    else if (instr_grant)
                        fetch_sent <= 1'b1;
                end
                PH_DECODE:
                begin
                    case (instr.opcode)
                        OP_ACCEPT:
                        begin
                            status.accepted <= 1'b1;
                            status.running  <= 1'b0;
                            phase           <= PH_IDLE;
                        end
                        OP_JMP:
                        begin
                            pc    <= instr.operand[PC_WIDTH-1:0];
                            phase <= PH_FETCH;
                        end
                        default:
                            phase <= PH_WAIT_CHAR;
                    endcase
                end
                PH_WAIT_CHAR:
                begin
                    if (char_ready && char_hit)
                    begin
                        pc              <= pc + 1'b1;
                        status.consumed <= 1'b1;
                        phase           <= PH_FETCH;
                    end
                    else if (char_ready)
                    begin
                        // thread dies on a mismatch or past the string end
                        status.running <= 1'b0;
                        phase          <= PH_IDLE;
                    end
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // instruction word captured from the memory response
    always_ff @(posedge clk)
    begin
        if (phase == PH_FETCH && instr_valid)
            instr <= instr_t'(memory_data);
    end

    // program lives at word address pc
    assign instr_req.valid = (phase == PH_FETCH) && !fetch_sent;
    assign instr_req.addr  = REQ_ADDR_WIDTH'(pc);

endmodule

//--- hdl/char_buffer.sv
//**********************************************************
// memory word buffer and current character register
//**********************************************************
module char_buffer
    import regex_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     word_load,
    input  logic [WORD_WIDTH-1:0]    memory_data,
    input  logic [CHAR_SEL_BITS-1:0] char_sel,
    output logic [CHAR_WIDTH-1:0]    cur_char
);
    logic [WORD_WIDTH-1:0] word_q;
    logic [WORD_WIDTH-1:0] src_word;
    logic [CHAR_WIDTH-1:0] char_q;

    // a fresh word bypasses the buffer so its char is ready next cycle
    assign src_word = word_load ? memory_data : word_q;

    // one fetch serves every char of the word
    always_ff @(posedge clk)
    begin
        if (word_load)
            word_q <= memory_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            char_q <= '0;
        else
            char_q <= src_word[char_sel*CHAR_WIDTH +: CHAR_WIDTH];
    end

    assign cur_char = char_q;

endmodule

//--- hdl/string_cursor.sv
//**********************************************************
// character pointer with word boundary and past-end flags
//**********************************************************
module string_cursor
    import regex_pkg::*;
#(
    parameter int ADDR_WIDTH = 11
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_start,
    input  logic [ADDR_WIDTH:0]   start_pointer,
    input  logic [ADDR_WIDTH:0]   end_pointer,
    input  logic                  advance,
    output logic [ADDR_WIDTH:0]   char_addr,
    output logic [ADDR_WIDTH-1:0] word_addr,
    output logic                  word_boundary,
    output logic                  past_end
);
    logic [ADDR_WIDTH:0] ptr_q;
    // inclusive last character of the job
    logic [ADDR_WIDTH:0] end_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr_q <= '0;
            end_q <= '0;
        end
        else if (load_start)
        begin
            ptr_q <= start_pointer;
            end_q <= end_pointer;
        end
        else if (advance)
            ptr_q <= ptr_q + 1'b1;
    end

    assign char_addr     = ptr_q;
    // upper bits address the word, lower bits the char in it
    assign word_addr     = ptr_q[CHAR_SEL_BITS +: ADDR_WIDTH];
    assign word_boundary = (ptr_q[CHAR_SEL_BITS-1:0] == '0);
    assign past_end      = (ptr_q > end_q);

endmodule

//--- hdl/coprocessor_fsm.sv
//**********************************************************
// job FSM with start checks, first word fetch, execution,
// character advance, completion and error
//**********************************************************
module coprocessor_fsm
    import regex_pkg::*;
#(
    parameter int ADDR_WIDTH = 11
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    output logic                  ready,
    input  logic [ADDR_WIDTH:0]   start_pointer,
    input  logic [ADDR_WIDTH:0]   end_pointer,
    input  logic [ADDR_WIDTH-1:0] word_addr,
    input  logic                  word_boundary,
    input  logic                  past_end,
    input  logic                  char_grant,
    input  logic                  char_word_valid,
    output mem_req_t              char_req,
    output logic                  load_start,
    output logic                  advance,
    output logic                  word_load,
    output logic                  char_ready,
    output logic                  engine_start,
    input  engine_status_t        status,
    output logic                  done,
    output logic                  accept,
    output logic                  error
);
    job_state_e state;
    job_state_e state_next;
    // word request of ST_LOAD_WORD already transferred
    logic       req_sent;
    logic       bad_job;

    // first char must sit at the word start, and the string must not be empty
    assign bad_job = (start_pointer[CHAR_SEL_BITS-1:0] != '0) || (end_pointer < start_pointer);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            req_sent <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (word_load)
                req_sent <= 1'b0;
            else if (char_grant)
                req_sent <= 1'b1;
        end
    end

    always_comb
    begin
        state_next     = state;
        char_req.valid = 1'b0;
        char_req.addr  = REQ_ADDR_WIDTH'(word_addr);
        ready          = 1'b0;
        load_start     = 1'b0;
        advance        = 1'b0;
        word_load      = 1'b0;
        engine_start   = 1'b0;
        case (state)
            ST_IDLE:
            begin
                // no word request is ever pending in idle
                ready = 1'b1;
                if (valid)
                begin
                    if (bad_job)
                        state_next = ST_ERROR;
                    else
                    begin
                        load_start = 1'b1;
                        state_next = ST_FETCH_FIRST;
                    end
                end
            end
            ST_FETCH_FIRST:
            begin
                // flush the engine and set pc back to 0
                engine_start = 1'b1;
                state_next   = ST_LOAD_WORD;
            end
            ST_LOAD_WORD:
            begin
                // hold the request until granted, then wait for its data
                char_req.valid = !req_sent;
                if (char_word_valid)
                begin
                    word_load  = 1'b1;
                    state_next = ST_EXE;
                end
            end
            ST_EXE:
            begin
                if (status.accepted)
                    state_next = ST_DONE_ACCEPT;
                else if (!status.running)
                    state_next = ST_DONE_REJECT;
                else if (status.consumed)
                begin
                    advance    = 1'b1;
                    state_next = ST_NEXT_CHAR;
                end
            end
            ST_NEXT_CHAR:
            begin
                // cursor has moved; past the end the engine fails on its own
                if (past_end || !word_boundary)
                    state_next = ST_EXE;
                else
                    state_next = ST_LOAD_WORD;
            end
            ST_DONE_ACCEPT, ST_DONE_REJECT:
                state_next = ST_IDLE;
            // sticky until rst
            ST_ERROR:
                state_next = ST_ERROR;
            default:
                state_next = ST_IDLE;
        endcase
    end

    assign char_ready = (state == ST_EXE);
    assign done       = (state == ST_DONE_ACCEPT) || (state == ST_DONE_REJECT);
    assign accept     = (state == ST_DONE_ACCEPT);
    assign error      = (state == ST_ERROR);

endmodule

//--- hdl/regex_pkg.sv
//**********************************************************
// shared widths, opcode and state enums, memory request,
// engine status and instruction word structs
//**********************************************************
package regex_pkg;

    // one memory word carries two characters
    localparam int CHAR_WIDTH     = 8;
    localparam int WORD_WIDTH     = 16;
    localparam int CHARS_PER_WORD = WORD_WIDTH / CHAR_WIDTH;
    localparam int CHAR_SEL_BITS  = $clog2(CHARS_PER_WORD);
    // request address field, covers any memory up to 16 address bits
    localparam int REQ_ADDR_WIDTH = 16;

    typedef enum logic [1:0] {
        OP_ACCEPT,
        OP_MATCH_CHAR,
        OP_MATCH_ANY,
        OP_JMP
    } opcode_e;

    // instruction word as stored in memory
    typedef struct packed {
        opcode_e               opcode;
        logic [5:0]            reserved;
        // literal character or jump target
        logic [CHAR_WIDTH-1:0] operand;
    } instr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_FIRST,
        ST_EXE,
        ST_LOAD_WORD,
        ST_NEXT_CHAR,
        ST_DONE_ACCEPT,
        ST_DONE_REJECT,
        ST_ERROR
    } job_state_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FETCH,
        PH_DECODE,
        PH_WAIT_CHAR
    } engine_phase_e;

    typedef struct packed {
        logic                      valid;
        logic [REQ_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic running;
        logic accepted;
        logic consumed;
    } engine_status_t;

endpackage
